/* verilog.f */
+incdir+logic
logic/video_pkg.sv
logic/video_timing.sv
logic/line_buffer_ram.sv
logic/scale_addr_gen.sv
logic/status_sync.sv
logic/pixel_formatter.sv
logic/video_mem.sv
test/video_mem_tb.sv

/* test/video_mem_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "video_cfg.svh"

module video_mem_tb
	import video_pkg::*;
();

	localparam int CPU_N = 8;
	localparam int SAMPLE_N = 11;
	localparam int FRAME_CLKS = 400000; // More than one frame of clk cycles.
	localparam int FRAME_PIX = 450000; // More than one frame of pixel_clk cycles.
	localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
	localparam int BUF_ROWS = 1 << (`VID_ADDR_WIDTH - `ROW_LSB);

	logic clk, pixel_clk, reset, wen, ren;
	buf_addr_t addr, curr_vid_addr;
	pixel_word_t data_in, data_out;
	logic next_field_out, de, hsync, vsync;
	color_t red, green, blue;

	integer seed;
	int errors = 0;
	int checks = 0;
	logic timed_out = 1'b0;

	// CPU table with words from the seeded generator.
	buf_addr_t cpu_addr [CPU_N] = '{11'h000, 11'h7ff, 11'h155, 11'h2aa,
		11'h3ff, 11'h400, 11'h1f0, 11'h60c};
	pixel_word_t cpu_word [CPU_N];

	// Pixel table sorted by line then by pixel.
	int sample_x [SAMPLE_N] = '{0, 639, 3, 4, 100, 100, 321, 5, 358, 0, 639};
	int sample_y [SAMPLE_N] = '{0, 0, 1, 1, 2, 3, 4, 5, 240, 479, 479};
	string sample_name [SAMPLE_N] = '{"top_left", "top_right", "col_hold_a",
		"col_hold_b", "row_two", "row_hold", "row_three", "row_wrap", "center",
		"bottom_left", "bottom_right"};

	video_mem UUT (
		.clk(clk), .reset(reset), .pixel_clk(pixel_clk),
		.addr(addr), .data_in(data_in), .wen(wen), .ren(ren), .data_out(data_out),
		.curr_vid_addr(curr_vid_addr), .next_field_out(next_field_out),
		.red(red), .green(green), .blue(blue),
		.de(de), .hsync(hsync), .vsync(vsync)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns.
	end

	initial begin
		pixel_clk = 1'b0;
		forever #15 pixel_clk = ~pixel_clk; // 30 ns period unrelated to clk.
	end

	// Fill pattern in which every address bit shows up.
	function automatic pixel_word_t pattern(input int a);
		logic [10:0] b;
		b = a[10:0];
		return {b[7:0] ^ 8'h3c, b[10:3], b[7:0]};
	endfunction

	function automatic int source_row(input int y);
		return (2 * y + 2) / 3; // 2:3 vertical.
	endfunction

	function automatic int source_col(input int x);
		return (3 * x + 3) / 4; // 3:4 horizontal.
	endfunction

	function automatic int scaled_addr(input int x, input int y);
		return (source_row(y) % BUF_ROWS) * (1 << `ROW_LSB) + source_col(x);
	endfunction

	task automatic mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
	endtask

	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("Timeout: %s.", what);
	endtask

	// One CPU port cycle driven on the falling edge.
	task automatic cpu_drive(input buf_addr_t a, input pixel_word_t d, input logic w,
		input logic r);
		@(negedge clk);
		addr = a;
		data_in = d;
		wen = w;
		ren = r;
	endtask

	task automatic cpu_test();
		for (int i = 0; i < CPU_N; i++) begin
			cpu_drive(cpu_addr[i], cpu_word[i], 1'b1, 1'b0);
		end
		for (int i = 0; i < CPU_N; i++) begin
			cpu_drive(cpu_addr[i] ^ 11'h020, ~cpu_word[i], 1'b1, 1'b0); // Neighbours.
		end
		for (int i = 0; i < CPU_N; i++) begin
			cpu_drive(cpu_addr[i], '0, 1'b0, 1'b1);
			cpu_drive(cpu_addr[i], '0, 1'b0, 1'b0); // Word is out now.
			checks++;
			if (data_out !== cpu_word[i])
				mismatch($sformatf("cpu_read_%0d", i), cpu_word[i], data_out);
		end
		cpu_drive(cpu_addr[0], ~cpu_word[0], 1'b1, 1'b1); // Same address, same cycle.
		cpu_drive(cpu_addr[0], '0, 1'b0, 1'b0);
		checks++;
		if (data_out !== cpu_word[0])
			mismatch("cpu_same_cycle_old", cpu_word[0], data_out);
		cpu_drive(cpu_addr[0], '0, 1'b0, 1'b1);
		cpu_drive(cpu_addr[0], '0, 1'b0, 1'b0);
		checks++;
		if (data_out !== ~cpu_word[0])
			mismatch("cpu_same_cycle_new", ~cpu_word[0], data_out);
	endtask

	task automatic wait_frame_pulse();
		int n;
		n = 0;
		while (next_field_out !== 1'b1 && n < FRAME_CLKS) begin
			@(negedge clk);
			n++;
		end
		if (next_field_out !== 1'b1)
			report_timeout("next_field_out did not pulse within a frame");
	endtask

	// One frame of pixel samples and line widths.
	task automatic scan_pixels();
		int x, y, k, n, lines;
		logic de_prev;
		pixel_word_t w;
		x = 0;
		y = -1;
		k = 0;
		n = 0;
		lines = 0;
		de_prev = 1'b0;
		while (lines < `V_ACTIVE && n < FRAME_PIX) begin
			@(negedge pixel_clk);
			n++;
			if (de && !de_prev) begin
				y++; // New active line.
				x = 0;
			end
			if (de) begin
				if (k < SAMPLE_N && x == sample_x[k] && y == sample_y[k]) begin
					w = pattern(scaled_addr(x, y));
					checks++;
					if (red !== w[7:0])
						mismatch({sample_name[k], "_red"}, w[7:0], red);
					if (green !== w[15:8])
						mismatch({sample_name[k], "_green"}, w[15:8], green);
					if (blue !== w[23:16])
						mismatch({sample_name[k], "_blue"}, w[23:16], blue);
					k++;
				end
				x++;
			end else if (de_prev) begin
				checks++;
				if (x != `H_ACTIVE)
					mismatch($sformatf("line_%0d_width", y), `H_ACTIVE, x);
				lines++;
			end
			de_prev = de;
		end
		if (lines < `V_ACTIVE) begin
			report_timeout("the active lines of a frame did not arrive");
		end else begin
			checks++;
			if (k != SAMPLE_N)
				mismatch("samples_seen", SAMPLE_N, k);
		end
	endtask

	// Address reports and sync counts on clk up to the next frame pulse.
	task automatic watch_raster();
		int n, lines, hsync_falls, vsync_lines, wait_left, expected;
		logic de_prev, hsync_prev;
		n = 0;
		lines = 0;
		hsync_falls = 0;
		vsync_lines = 0;
		wait_left = 0;
		de_prev = de;
		hsync_prev = hsync;
		while (next_field_out !== 1'b1 && n < FRAME_CLKS) begin
			@(negedge clk);
			n++;
			if (hsync_prev && !hsync) begin
				hsync_falls++;
				if (!vsync)
					vsync_lines++; // Line inside the vertical sync pulse.
			end
			if (wait_left > 0) begin
				wait_left--;
				if (wait_left == 0) begin
					expected = (source_row(lines + 1) % BUF_ROWS) * (1 << `ROW_LSB);
					checks++;
					if (curr_vid_addr !== expected)
						mismatch($sformatf("addr_report_%0d", lines), expected, curr_vid_addr);
					lines++;
				end
			end else if (de_prev && !de) begin
				wait_left = 20; // Address is settled during blanking.
			end
			de_prev = de;
			hsync_prev = hsync;
		end
		if (next_field_out !== 1'b1) begin
			report_timeout("the second next_field_out pulse did not arrive");
		end else begin
			checks++;
			if (hsync_falls != V_TOTAL)
				mismatch("hsync_pulses", V_TOTAL, hsync_falls);
			checks++;
			if (vsync_lines != `V_SYNC)
				mismatch("vsync_lines", `V_SYNC, vsync_lines);
			checks++;
			if (lines != `V_ACTIVE)
				mismatch("active_lines", `V_ACTIVE, lines);
		end
	endtask

	initial begin
		seed = 32'h6d9c_f95e;
		reset = 1'b1;
		addr = '0;
		data_in = '0;
		wen = 1'b0;
		ren = 1'b0;
		for (int i = 0; i < CPU_N; i++) begin
			cpu_word[i] = pixel_word_t'($random(seed));
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		checks++;
		if (de !== 1'b0 || hsync !== 1'b1 || vsync !== 1'b1 || next_field_out !== 1'b0)
			mismatch("reset_levels", 4'b0110, {de, hsync, vsync, next_field_out});
		reset = 1'b0;
		cpu_test();
		for (int a = 0; a < (1 << `VID_ADDR_WIDTH); a++) begin
			cpu_drive(buf_addr_t'(a), pattern(a), 1'b1, 1'b0);
		end
		cpu_drive('0, '0, 1'b0, 1'b0);
		wait_frame_pulse();
		if (!timed_out) begin
			@(negedge clk);
			checks++;
			if (next_field_out !== 1'b0)
				mismatch("frame_pulse_width", 1'b0, next_field_out);
			fork
				scan_pixels();
				watch_raster();
			join
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* logic/video_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module video_mem
	import video_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic pixel_clk,
	input wire buf_addr_t addr,
	input wire pixel_word_t data_in,
	input wire logic wen,
	input wire logic ren,
	output pixel_word_t data_out,
	output buf_addr_t curr_vid_addr,
	output logic next_field_out,
	output color_t red,
	output color_t green,
	output color_t blue,
	output logic de,
	output logic hsync,
	output logic vsync
);

	logic pixel_reset; // Reset in pixel_clk.
	logic fetch_next;
	logic next_line;
	logic next_field;
	logic de_raw;
	logic hsync_raw;
	logic vsync_raw;
	buf_addr_t video_addr; // Scaled read address.
	pixel_word_t video_data; // Word one pixel_clk after video_addr.

	video_timing timing (
		.clk(pixel_clk),
		.pixel_reset(pixel_reset),
		.fetch_next(fetch_next),
		.next_line(next_line),
		.next_field(next_field),
		.de_raw(de_raw),
		.hsync_raw(hsync_raw),
		.vsync_raw(vsync_raw)
	);

	line_buffer_ram ram (
		.clk(clk),
		.addr(addr),
		.data_in(data_in),
		.wen(wen),
		.ren(ren),
		.data_out(data_out),
		.pixel_clk(pixel_clk),
		.video_addr(video_addr),
		.video_data(video_data)
	);

	scale_addr_gen scaler (
		.pixel_clk(pixel_clk),
		.pixel_reset(pixel_reset),
		.fetch_next(fetch_next),
		.next_line(next_line),
		.next_field(next_field),
		.video_addr(video_addr)
	);

	status_sync xing (
		.clk(clk),
		.reset(reset),
		.pixel_clk(pixel_clk),
		.next_field(next_field),
		.video_addr(video_addr),
		.pixel_reset(pixel_reset),
		.curr_vid_addr(curr_vid_addr),
		.next_field_out(next_field_out)
	);

	pixel_formatter formatter (
		.pixel_clk(pixel_clk),
		.pixel_reset(pixel_reset),
		.video_data(video_data),
		.de_raw(de_raw),
		.hsync_raw(hsync_raw),
		.vsync_raw(vsync_raw),
		.red(red),
		.green(green),
		.blue(blue),
		.de(de),
		.hsync(hsync),
		.vsync(vsync)
	);

endmodule

`default_nettype wire

/* logic/pixel_formatter.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_formatter
	import video_pkg::*;
(
	input wire logic pixel_clk,
	input wire logic pixel_reset,
	input wire pixel_word_t video_data,
	input wire logic de_raw,
	input wire logic hsync_raw,
	input wire logic vsync_raw,
	output color_t red,
	output color_t green,
	output color_t blue,
	output logic de,
	output logic hsync,
	output logic vsync
);

	logic de_d1; // Lines up with video_data.
	logic hsync_d1;
	logic vsync_d1;

	// Two stage delay of the raw levels.
	always_ff @(posedge pixel_clk) begin
		if (pixel_reset) begin
			de_d1 <= 1'b0;
			hsync_d1 <= 1'b1; // Sync idles high.
			vsync_d1 <= 1'b1;
			de <= 1'b0;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end else begin
			de_d1 <= de_raw;
			hsync_d1 <= hsync_raw;
			vsync_d1 <= vsync_raw;
			de <= de_d1;
			hsync <= hsync_d1;
			vsync <= vsync_d1;
		end
	end

	// Colour register is black outside the visible area.
	always_ff @(posedge pixel_clk) begin
		if (de_d1) begin
			red <= video_data[7:0];
			green <= video_data[15:8];
			blue <= video_data[23:16];
		end else begin
			red <= '0;
			green <= '0;
			blue <= '0;
		end
	end

endmodule

`default_nettype wire

/* logic/status_sync.sv */
`timescale 1ns/10ps
`default_nettype none

module status_sync
	import video_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic pixel_clk,
	input wire logic next_field,
	input wire buf_addr_t video_addr,
	output logic pixel_reset,
	output buf_addr_t curr_vid_addr,
	output logic next_field_out
);

	logic rst_meta; // First reset flop in pixel_clk.
	buf_addr_t addr_meta; // Address crossing stages.
	buf_addr_t addr_sync;
	logic field_toggle; // Flips on each frame start.
	logic toggle_meta;
	logic toggle_sync;
	logic toggle_prev; // Edge detector history.

	always_ff @(posedge pixel_clk) begin
		rst_meta <= reset;
		pixel_reset <= rst_meta; // Two pixel_clk cycles behind reset.
	end

	always_ff @(posedge pixel_clk) begin
		if (pixel_reset) begin
			field_toggle <= 1'b0;
		end else if (next_field) begin
			field_toggle <= ~field_toggle; // Pulse becomes a level change.
		end
	end

	// Only stable during horizontal blanking.
	always_ff @(posedge clk) begin
		addr_meta <= video_addr;
		addr_sync <= addr_meta;
		curr_vid_addr <= addr_sync; // Three clk cycles behind.
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			toggle_meta <= 1'b0;
			toggle_sync <= 1'b0;
			toggle_prev <= 1'b0;
			next_field_out <= 1'b0;
		end else begin
			toggle_meta <= field_toggle;
			toggle_sync <= toggle_meta;
			toggle_prev <= toggle_sync;
			next_field_out <= toggle_sync ^ toggle_prev; // One clk pulse per edge.
		end
	end

	// Frames are far apart, so the pulse is always single.
	assert property (@(posedge clk) disable iff (reset) next_field_out |=> !next_field_out);

endmodule

`default_nettype wire

/* logic/scale_addr_gen.sv */
`timescale 1ns/10ps
`default_nettype none
`include "video_cfg.svh"

module scale_addr_gen
	import video_pkg::*;
(
	input wire logic pixel_clk,
	input wire logic pixel_reset,
	input wire logic fetch_next,
	input wire logic next_line,
	input wire logic next_field,
	output buf_addr_t video_addr
);

	localparam int ROW_BITS = `VID_ADDR_WIDTH - `ROW_LSB;

	// 640/480 = 4/3 horizontally, 480/320 = 3/2 vertically.
	logic [1:0] col_skip; // Column repeats on count 3.
	logic [1:0] row_skip; // Row repeats on count 2.
	logic [`ROW_LSB-1:0] col; // Source column.
	logic [ROW_BITS-1:0] row; // Source row, wraps over the buffer.

	always_ff @(posedge pixel_clk) begin
		if (pixel_reset) begin
			col_skip <= '0;
			row_skip <= '0;
			col <= '0;
			row <= '0;
		end else if (next_field) begin
			col_skip <= '0; // New frame starts at row 0.
			row_skip <= '0;
			col <= '0;
			row <= '0;
		end else if (next_line) begin
			col_skip <= '0;
			row_skip <= (row_skip == 2'd2) ? 2'd0 : row_skip + 2'd1;
			if (row_skip != 2'd2) begin
				row <= row + 1'b1; // Two of three lines step.
			end
			col <= '0; // Back to column 0.
		end else if (fetch_next) begin
			col_skip <= col_skip + 2'd1; // Wraps every 4 pixels.
			if (col_skip != 2'd3) begin
				col <= col + 1'b1; // Three of four pixels step.
			end
		end
	end

	assign video_addr = {row, col};

	// Modulo-3 counter stays in range.
	assert property (@(posedge pixel_clk) disable iff (pixel_reset) row_skip != 2'd3);

endmodule

`default_nettype wire

/* logic/line_buffer_ram.sv */
`timescale 1ns/10ps
`default_nettype none
`include "video_cfg.svh"

module line_buffer_ram
	import video_pkg::*;
(
	input wire logic clk,
	input wire buf_addr_t addr,
	input wire pixel_word_t data_in,
	input wire logic wen,
	input wire logic ren,
	output pixel_word_t data_out,
	input wire logic pixel_clk,
	input wire buf_addr_t video_addr,
	output pixel_word_t video_data
);

	localparam int DEPTH = 2 ** `VID_ADDR_WIDTH; // 2048 words for 11 bits.

	pixel_word_t mem [0:DEPTH-1]; // Four rows of 512 pixels.

	// CPU port.
	always_ff @(posedge clk) begin
		if (wen) begin
			mem[addr] <= data_in; // Write at the edge.
		end
		if (ren) begin
			data_out <= mem[addr]; // Old word on a same-address write.
		end
	end

	// Read-only video port.
	always_ff @(posedge pixel_clk) begin
		video_data <= mem[video_addr]; // One cycle read latency.
	end

	// CPU writes need a clean address.
	assert property (@(posedge clk) wen |-> !$isunknown(addr));

endmodule

`default_nettype wire

/* logic/video_timing.sv */
`timescale 1ns/10ps
`default_nettype none
`include "video_cfg.svh"

module video_timing
	import video_pkg::*;
(
	input wire logic clk,
	input wire logic pixel_reset,
	output logic fetch_next,
	output logic next_line,
	output logic next_field,
	output logic de_raw,
	output logic hsync_raw,
	output logic vsync_raw
);

	localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
	localparam vcount_t V_SYNC_FIRST = vcount_t'(`V_ACTIVE + `V_FRONT);
	localparam vcount_t V_SYNC_END = vcount_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);
	localparam vcount_t V_LAST = vcount_t'(V_TOTAL - 1);

	line_state_t state; // Horizontal phase.
	line_state_t state_next;
	hcount_t hcount; // Cycle inside the current phase.
	hcount_t phase_last; // Last count of the current phase.
	vcount_t vcount; // Current line.
	logic phase_done;
	logic active_line;

	always_comb begin
		case (state)
			active: phase_last = hcount_t'(`H_ACTIVE - 1);
			front: phase_last = hcount_t'(`H_FRONT - 1);
			sync: phase_last = hcount_t'(`H_SYNC - 1);
			default: phase_last = hcount_t'(`H_BACK - 1);
		endcase
	end

	always_comb begin
		case (state)
			active: state_next = front;
			front: state_next = sync;
			sync: state_next = back;
			default: state_next = active; // Back porch closes the line.
		endcase
	end

	assign phase_done = (hcount == phase_last);
	assign active_line = (vcount < vcount_t'(`V_ACTIVE));

	always_ff @(posedge clk) begin
		if (pixel_reset) begin
			state <= active; // Start at pixel 0 of line 0.
			hcount <= '0;
			vcount <= '0;
		end else begin
			if (phase_done) begin
				state <= state_next;
				hcount <= '0;
			end else begin
				hcount <= hcount + 1'b1;
			end
			if (phase_done && state == back) begin // End of line.
				vcount <= (vcount == V_LAST) ? '0 : vcount + 1'b1;
			end
		end
	end

	// Strobes for the address generator.
	assign fetch_next = (state == active) && active_line; // One per visible pixel.
	assign next_line = (state == front) && (hcount == '0) && active_line;
	assign next_field = (state == active) && (hcount == '0) && (vcount == V_SYNC_FIRST);

	// Raw video levels aligned with hcount.
	assign de_raw = fetch_next; // Visible area equals the fetch window.
	assign hsync_raw = (state != sync); // Active low.
	assign vsync_raw = !((vcount >= V_SYNC_FIRST) && (vcount < V_SYNC_END)); // Active low.

	// A line step always follows the last fetch of the line directly.
	assert property (@(posedge clk) disable iff (pixel_reset)
		next_line |-> !fetch_next && $past(fetch_next));

endmodule

`default_nettype wire

/* logic/video_pkg.sv */
`default_nettype none
`include "video_cfg.svh"

package video_pkg;

	typedef logic [23:0] pixel_word_t; // Blue 23:16, green 15:8, red 7:0.
	typedef logic [7:0] color_t; // One colour channel.

	typedef logic [`VID_ADDR_WIDTH-1:0] buf_addr_t; // Row above ROW_LSB, column below.

	typedef logic [9:0] hcount_t; // Count inside a horizontal phase.
	typedef logic [9:0] vcount_t; // Line number in the frame.

	// Horizontal phase of the raster.
	typedef enum logic [1:0] {
		active,
		front,
		sync,
		back
	} line_state_t;

endpackage

`default_nettype wire

/* logic/video_cfg.svh */
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// Line buffer geometry.
`define VID_ADDR_WIDTH 11 // Must be 9 or more.
`define ROW_LSB 9 // Column is below this bit, row is above.

// Horizontal 640x480 timing in pixel_clk cycles.
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48

// Vertical 640x480 timing in lines.
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

`endif
